/* core_macros.svh */
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// Datapath width in bits
`define CORE_XLEN 32

// Architectural register count, r0 included
`define CORE_NREGS 32

// Width of a register number
`define CORE_RADDR_W 5

// Instruction buffer entries
`define CORE_IB_DEPTH 4

`endif

/* core_isa_pkg.sv */
`default_nettype none

`include "core_macros.svh"

package core_isa_pkg;

    typedef logic [`CORE_XLEN-1:0]    word_t;
    typedef logic [`CORE_XLEN-1:0]    pc_t;
    typedef logic [31:0]              instr_t;
    typedef logic [`CORE_RADDR_W-1:0] reg_addr_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_MUL,
        ALU_LUI,  // Passes b, immediate already shifted
        ALU_NOP
    } alu_op_e;

    // 3R format, opcode in bits 31:15
    localparam int          F_OPC3R_LSB = 15;
    localparam logic [16:0] OPC3R_ADD   = 17'h00020;
    localparam logic [16:0] OPC3R_SUB   = 17'h00022;
    localparam logic [16:0] OPC3R_AND   = 17'h00029;
    localparam logic [16:0] OPC3R_OR    = 17'h0002A;
    localparam logic [16:0] OPC3R_XOR   = 17'h0002B;
    localparam logic [16:0] OPC3R_MUL   = 17'h00038;

    // 2RI12 and 1RI20 formats
    localparam int          F_OPC10_LSB = 22;
    localparam logic [9:0]  OPC_ADDI    = 10'h00A;
    localparam int          F_OPC7_LSB  = 25;
    localparam logic [6:0]  OPC_LU12I   = 7'h0A;

    // Operand fields
    localparam int F_RD_LSB   = 0;
    localparam int F_RJ_LSB   = 5;
    localparam int F_RK_LSB   = 10;
    localparam int F_SI12_LSB = 10;
    localparam int SI12_W     = 12;
    localparam int F_SI20_LSB = 5;
    localparam int SI20_W     = 20;

endpackage

`default_nettype wire

/* core_pipe_pkg.sv */
`default_nettype none

package core_pipe_pkg;

    import core_isa_pkg::*;

    // Fetch port and buffer entry
    typedef struct packed {
        pc_t    pc;
        instr_t instr;
    } fetch_item_s;

    // Decode output
    typedef struct packed {
        logic      valid;
        pc_t       pc;
        alu_op_e   op;
        reg_addr_t rj;
        reg_addr_t rk;
        reg_addr_t rd;
        logic      use_imm;
        word_t     imm;      // Sign-extended, or shifted for lu12i.w
        logic      we;       // Low for r0 and unknown encodings
    } decoded_s;

    // Dispatch to execute
    typedef struct packed {
        logic      valid;
        pc_t       pc;
        alu_op_e   op;
        reg_addr_t rd;
        logic      we;
        word_t     a;
        word_t     b;
    } issue_s;

    // Writeback, also the forwarding source
    typedef struct packed {
        logic      valid;
        pc_t       pc;
        logic      we;
        reg_addr_t waddr;
        word_t     wdata;
    } commit_s;

endpackage

`default_nettype wire

/* instr_buffer.sv */
`timescale 1ns/1ns
`default_nettype none

`include "core_macros.svh"

module instr_buffer import core_pipe_pkg::*; (
    input  wire         clk,
    input  wire         rst_n_i,
    input  logic        push_valid_i,
    input  fetch_item_s push_item_i,
    output logic        push_ready_o,
    input  logic        pop_i,
    output logic        head_valid_o,
    output fetch_item_s head_item_o
);

    localparam int DEPTH = `CORE_IB_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    fetch_item_s      mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             push;
    logic             pop;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign push_ready_o = (count_q != CNT_W'(DEPTH));  // Low only when full
    assign head_valid_o = (count_q != '0);
    assign head_item_o  = mem_q[rd_ptr_q];              // Head visible with no pop delay

    assign push = push_valid_i && push_ready_o;
    assign pop  = pop_i && head_valid_o;

    always_ff @(posedge clk) begin
        if (push) begin
            mem_q[wr_ptr_q] <= push_item_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;  // Both or neither
            endcase
        end
    end

endmodule

`default_nettype wire

/* decoder.sv */
`timescale 1ns/1ns
`default_nettype none

module decoder import core_isa_pkg::*, core_pipe_pkg::*; (
    input  logic        item_valid_i,
    input  fetch_item_s item_i,
    output decoded_s    dec_o
);

    instr_t            ins;
    logic [16:0]       opc3r;
    logic [9:0]        opc10;
    logic [6:0]        opc7;
    logic [SI12_W-1:0] si12;
    logic [SI20_W-1:0] si20;
    logic              known;

    assign ins   = item_i.instr;
    assign opc3r = ins[31:F_OPC3R_LSB];
    assign opc10 = ins[31:F_OPC10_LSB];
    assign opc7  = ins[31:F_OPC7_LSB];
    assign si12  = ins[F_SI12_LSB +: SI12_W];
    assign si20  = ins[F_SI20_LSB +: SI20_W];

    always_comb begin
        known         = 1'b1;
        dec_o.valid   = item_valid_i;
        dec_o.pc      = item_i.pc;
        dec_o.rd      = ins[F_RD_LSB +: `CORE_RADDR_W];
        dec_o.rj      = ins[F_RJ_LSB +: `CORE_RADDR_W];
        dec_o.rk      = ins[F_RK_LSB +: `CORE_RADDR_W];
        dec_o.op      = ALU_NOP;
        dec_o.use_imm = 1'b0;
        dec_o.imm     = '0;

        if (opc7 == OPC_LU12I) begin
            dec_o.op      = ALU_LUI;
            dec_o.use_imm = 1'b1;
            dec_o.imm     = {si20, 12'b0};
        end else if (opc10 == OPC_ADDI) begin
            dec_o.op      = ALU_ADD;
            dec_o.use_imm = 1'b1;
            dec_o.imm     = {{(`CORE_XLEN - SI12_W){si12[SI12_W-1]}}, si12};
        end else begin
            case (opc3r)
                OPC3R_ADD: dec_o.op = ALU_ADD;
                OPC3R_SUB: dec_o.op = ALU_SUB;
                OPC3R_AND: dec_o.op = ALU_AND;
                OPC3R_OR:  dec_o.op = ALU_OR;
                OPC3R_XOR: dec_o.op = ALU_XOR;
                OPC3R_MUL: dec_o.op = ALU_MUL;
                default:   known    = 1'b0;  // Commits as a NOP with wen low
            endcase
        end

        // r0 never written
        dec_o.we = item_valid_i && known && (dec_o.rd != '0);
    end

endmodule

`default_nettype wire

/* regfile.sv */
`timescale 1ns/1ns
`default_nettype none

`include "core_macros.svh"

module regfile import core_isa_pkg::*; (
    input  wire       clk,
    input  wire       rst_n_i,
    input  reg_addr_t raddr_a_i,
    input  reg_addr_t raddr_b_i,
    output word_t     rdata_a_o,
    output word_t     rdata_b_o,
    input  logic      we_i,
    input  reg_addr_t waddr_i,
    input  word_t     wdata_i
);

    word_t regs [1:`CORE_NREGS-1];  // No storage behind r0

    // Same-cycle write is passed through to the reader
    function automatic word_t read_port(input reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end else if (we_i && (waddr_i == addr)) begin
            return wdata_i;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rdata_a_o = read_port(raddr_a_i);
        rdata_b_o = read_port(raddr_b_i);
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < `CORE_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

endmodule

`default_nettype wire

/* dispatch.sv */
`timescale 1ns/1ns
`default_nettype none

module dispatch import core_isa_pkg::*, core_pipe_pkg::*; (
    input  wire       clk,
    input  wire       rst_n_i,
    input  decoded_s  dec_i,
    output logic      ib_pop_o,
    output reg_addr_t raddr_a_o,
    output reg_addr_t raddr_b_o,
    input  word_t     rdata_a_i,
    input  word_t     rdata_b_i,
    input  commit_s   fwd_i,
    input  logic      ex_busy_i,
    output issue_s    issue_o
);

    word_t opnd_a;
    word_t opnd_rk;
    word_t opnd_b;

    // Result about to be registered in execute wins over the register file
    function automatic word_t pick_operand(
        input reg_addr_t addr,
        input word_t     rf_val,
        input commit_s   fwd
    );
        if (fwd.valid && fwd.we && (fwd.waddr == addr)) begin
            return fwd.wdata;
        end
        return rf_val;
    endfunction

    assign raddr_a_o = dec_i.rj;
    assign raddr_b_o = dec_i.rk;

    assign opnd_a  = pick_operand(dec_i.rj, rdata_a_i, fwd_i);
    assign opnd_rk = pick_operand(dec_i.rk, rdata_b_i, fwd_i);
    assign opnd_b  = dec_i.use_imm ? dec_i.imm : opnd_rk;

    assign ib_pop_o = dec_i.valid && !ex_busy_i;  // Head taken this edge

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            issue_o.valid <= 1'b0;
            issue_o.we    <= 1'b0;
        end else if (!ex_busy_i) begin
            issue_o.valid <= dec_i.valid;
            issue_o.we    <= dec_i.we;
            issue_o.pc    <= dec_i.pc;
            issue_o.op    <= dec_i.op;
            issue_o.rd    <= dec_i.rd;
            issue_o.a     <= opnd_a;
            issue_o.b     <= opnd_b;
        end
        // Held while the multiplier runs
    end

endmodule

`default_nettype wire

/* alu_ex.sv */
`timescale 1ns/1ns
`default_nettype none

`include "core_macros.svh"

module alu_ex import core_isa_pkg::*, core_pipe_pkg::*; (
    input  wire     clk,
    input  wire     rst_n_i,
    input  issue_s  issue_i,
    output logic    busy_o,
    output commit_s fwd_o,
    output commit_s commit_o
);

    localparam int STEP_W = $clog2(`CORE_XLEN);

    typedef enum logic [1:0] {
        MUL_IDLE,
        MUL_RUN,
        MUL_DONE
    } mul_state_e;

    mul_state_e        state_q;
    mul_state_e        state_d;
    logic [STEP_W-1:0] step_q;
    word_t             mcand_q;
    word_t             mplier_q;
    word_t             acc_q;
    word_t             alu_res;
    logic              is_mul;
    logic              mul_start;

    assign is_mul    = issue_i.valid && (issue_i.op == ALU_MUL);
    assign mul_start = (state_q == MUL_IDLE) && is_mul;

    always_comb begin
        case (issue_i.op)
            ALU_ADD: alu_res = issue_i.a + issue_i.b;
            ALU_SUB: alu_res = issue_i.a - issue_i.b;
            ALU_AND: alu_res = issue_i.a & issue_i.b;
            ALU_OR:  alu_res = issue_i.a | issue_i.b;
            ALU_XOR: alu_res = issue_i.a ^ issue_i.b;
            ALU_LUI: alu_res = issue_i.b;
            default: alu_res = '0;  // NOP, product comes from acc_q
        endcase
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            MUL_IDLE: if (is_mul) state_d = MUL_RUN;
            MUL_RUN:  if (step_q == STEP_W'(`CORE_XLEN - 1)) state_d = MUL_DONE;
            MUL_DONE: state_d = MUL_IDLE;
            default:  state_d = MUL_IDLE;
        endcase
    end

    // Dispatch must keep the mul in place until the product is ready
    assign busy_o = mul_start || (state_q == MUL_RUN);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= MUL_IDLE;
            step_q  <= '0;
        end else begin
            state_q <= state_d;
            if (mul_start) begin
                step_q <= '0;
            end else if (state_q == MUL_RUN) begin
                step_q <= step_q + 1'b1;
            end
        end
    end

    // Shift-add, one multiplier bit per cycle, low word kept
    always_ff @(posedge clk) begin
        if (mul_start) begin
            mcand_q  <= issue_i.a;
            mplier_q <= issue_i.b;
            acc_q    <= '0;
        end else if (state_q == MUL_RUN) begin
            if (mplier_q[0]) begin
                acc_q <= acc_q + mcand_q;
            end
            mcand_q  <= mcand_q << 1;
            mplier_q <= mplier_q >> 1;
        end
    end

    always_comb begin
        fwd_o.pc    = issue_i.pc;
        fwd_o.waddr = issue_i.rd;
        fwd_o.wdata = alu_res;
        fwd_o.valid = 1'b0;
        fwd_o.we    = 1'b0;
        if (state_q == MUL_DONE) begin
            fwd_o.valid = 1'b1;
            fwd_o.we    = issue_i.we;
            fwd_o.wdata = acc_q;
        end else if ((state_q == MUL_IDLE) && issue_i.valid && !is_mul) begin
            fwd_o.valid = 1'b1;  // Single-cycle ops
            fwd_o.we    = issue_i.we;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            commit_o <= '0;
        end else begin
            commit_o <= fwd_o;
        end
    end

endmodule

`default_nettype wire

/* core_top.sv */
`timescale 1ns/1ns
`default_nettype none

module core_top import core_isa_pkg::*, core_pipe_pkg::*; (
    input  wire         clk,
    input  wire         rst_n_i,
    input  logic        fetch_valid_i,
    input  fetch_item_s fetch_item_i,
    output logic        fetch_ready_o,
    output logic        debug_wb_valid_o,
    output pc_t         debug_wb_pc_o,
    output logic        debug_wb_rf_wen_o,
    output reg_addr_t   debug_wb_rf_wnum_o,
    output word_t       debug_wb_rf_wdata_o
);

    fetch_item_s ib_head;
    logic        ib_valid;
    logic        ib_pop;
    decoded_s    dec;
    reg_addr_t   rf_raddr_a;
    reg_addr_t   rf_raddr_b;
    word_t       rf_rdata_a;
    word_t       rf_rdata_b;
    issue_s      issue;
    logic        ex_busy;
    commit_s     ex_fwd;
    commit_s     wb;

    instr_buffer u_instr_buffer (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .push_valid_i (fetch_valid_i),
        .push_item_i  (fetch_item_i),
        .push_ready_o (fetch_ready_o),
        .pop_i        (ib_pop),
        .head_valid_o (ib_valid),
        .head_item_o  (ib_head)
    );

    decoder u_decoder (
        .item_valid_i (ib_valid),
        .item_i       (ib_head),
        .dec_o        (dec)
    );

    regfile u_regfile (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .raddr_a_i (rf_raddr_a),
        .raddr_b_i (rf_raddr_b),
        .rdata_a_o (rf_rdata_a),
        .rdata_b_o (rf_rdata_b),
        .we_i      (wb.valid && wb.we),
        .waddr_i   (wb.waddr),
        .wdata_i   (wb.wdata)
    );

    dispatch u_dispatch (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .dec_i     (dec),
        .ib_pop_o  (ib_pop),
        .raddr_a_o (rf_raddr_a),
        .raddr_b_o (rf_raddr_b),
        .rdata_a_i (rf_rdata_a),
        .rdata_b_i (rf_rdata_b),
        .fwd_i     (ex_fwd),
        .ex_busy_i (ex_busy),
        .issue_o   (issue)
    );

    alu_ex u_alu_ex (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .issue_i  (issue),
        .busy_o   (ex_busy),
        .fwd_o    (ex_fwd),
        .commit_o (wb)
    );

    // Debug commit port straight off the writeback register
    assign debug_wb_valid_o    = wb.valid;
    assign debug_wb_pc_o       = wb.pc;
    assign debug_wb_rf_wen_o   = wb.valid && wb.we;
    assign debug_wb_rf_wnum_o  = wb.waddr;
    assign debug_wb_rf_wdata_o = wb.wdata;

endmodule

`default_nettype wire

/* tb_core_tasks.svh */
`ifndef TB_CORE_TASKS_SVH
`define TB_CORE_TASKS_SVH

task automatic check_pc(input pc_t want, input pc_t got);
    if (got !== want) begin
        mismatch_cnt++;
        $display("mismatch %s: pc expected %h actual %h", cur_test, want, got);
    end
endtask

task automatic check_wnum(input reg_addr_t want, input reg_addr_t got);
    if (got !== want) begin
        mismatch_cnt++;
        $display("mismatch %s: wnum expected %0d actual %0d", cur_test, want, got);
    end
endtask

task automatic check_wdata(input word_t want, input word_t got);
    if (got !== want) begin
        mismatch_cnt++;
        $display("mismatch %s: wdata expected %h actual %h", cur_test, want, got);
    end
endtask

task automatic check_wen(input logic want, input logic got);
    if (got !== want) begin
        mismatch_cnt++;
        $display("mismatch %s: wen expected %b actual %b", cur_test, want, got);
    end
endtask

// LoongArch encodings, 3R, 2RI12 and 1RI20
function automatic instr_t encode(input ins_kind_e kind, input reg_addr_t rd,
                                  input reg_addr_t rj, input reg_addr_t rk,
                                  input logic [19:0] imm);
    case (kind)
        K_ADD:   return {OPC3R_ADD, rk, rj, rd};
        K_SUB:   return {OPC3R_SUB, rk, rj, rd};
        K_AND:   return {OPC3R_AND, rk, rj, rd};
        K_OR:    return {OPC3R_OR, rk, rj, rd};
        K_XOR:   return {OPC3R_XOR, rk, rj, rd};
        K_MUL:   return {OPC3R_MUL, rk, rj, rd};
        K_ADDI:  return {OPC_ADDI, imm[11:0], rj, rd};
        K_LU12I: return {OPC_LU12I, imm, rd};
        default: return {8'hFF, imm[18:0], rd};  // Top byte all ones is unused
    endcase
endfunction

function automatic word_t ref_result(input ins_kind_e kind, input word_t a, input word_t b,
                                     input logic [19:0] imm);
    case (kind)
        K_ADD:   return a + b;
        K_SUB:   return a - b;
        K_AND:   return a & b;
        K_OR:    return a | b;
        K_XOR:   return a ^ b;
        K_MUL:   return a * b;  // Low word only
        K_ADDI:  return a + {{20{imm[11]}}, imm[11:0]};
        K_LU12I: return {imm, 12'h000};
        default: return '0;
    endcase
endfunction

task automatic idle_cycles(input int n);
    repeat (n) @(negedge clk);
endtask

// Hold the item until the buffer takes it
task automatic push_fetch(input fetch_item_s item);
    fetch_valid_i = 1'b1;
    fetch_item_i  = item;
    while (fetch_ready_o !== 1'b1) begin
        ready_low_seen = 1'b1;
        @(negedge clk);
    end
    @(negedge clk);         // Taken at the rising edge just passed
    fetch_valid_i = 1'b0;
endtask

task automatic issue_op(input ins_kind_e kind, input reg_addr_t rd, input reg_addr_t rj,
                        input reg_addr_t rk, input logic [19:0] imm);
    fetch_item_s item;
    exp_commit_s want;
    item.pc    = next_pc;
    item.instr = encode(kind, rd, rj, rk, imm);
    want.pc    = next_pc;
    want.known = (kind != K_BAD);
    want.wen   = want.known && (rd != '0);
    want.wnum  = rd;
    want.wdata = ref_result(kind, model_regs[rj], model_regs[rk], imm);
    if (want.wen) begin
        model_regs[rd] = want.wdata;
    end
    exp_q.push_back(want);
    n_sent++;
    next_pc = next_pc + 32'd4;
    push_fetch(item);
endtask

// lu12i.w then addi.w, upper part rounded for the sign of the low 12 bits
task automatic load_reg(input reg_addr_t rd, input word_t value);
    word_t hi;
    hi = value + 32'h800;
    issue_op(K_LU12I, rd, 5'd0, 5'd0, hi[31:12]);
    issue_op(K_ADDI, rd, rd, 5'd0, {8'h00, value[11:0]});
endtask

task automatic wait_drain();
    while (exp_q.size() != 0) begin
        @(negedge clk);
    end
endtask

task automatic test_alu_basic();
    cur_test = "test_alu_basic";
    for (int r = 1; r <= 4; r++) begin
        load_reg(reg_addr_t'(r), word_t'($urandom()));
    end
    issue_op(K_ADD, 5'd10, 5'd1, 5'd2, '0);
    issue_op(K_SUB, 5'd11, 5'd3, 5'd4, '0);
    issue_op(K_AND, 5'd12, 5'd1, 5'd3, '0);
    issue_op(K_OR, 5'd13, 5'd2, 5'd4, '0);
    issue_op(K_XOR, 5'd14, 5'd1, 5'd4, '0);
    issue_op(K_ADDI, 5'd15, 5'd2, 5'd0, 20'h00F9C);  // Negative immediate
    wait_drain();
endtask

task automatic test_dependencies();
    cur_test = "test_dependencies";
    load_reg(5'd1, word_t'($urandom()));
    load_reg(5'd2, word_t'($urandom()));
    issue_op(K_ADD, 5'd3, 5'd1, 5'd2, '0);
    issue_op(K_SUB, 5'd3, 5'd3, 5'd1, '0);   // rj from the previous one
    issue_op(K_XOR, 5'd3, 5'd2, 5'd3, '0);   // rk side
    issue_op(K_ADDI, 5'd3, 5'd3, 5'd0, 20'h00007);
    issue_op(K_OR, 5'd4, 5'd3, 5'd3, '0);
    for (int i = 0; i < 4; i++) begin
        issue_op(K_ADD, 5'd5, 5'd5, 5'd3, '0);
        issue_op(K_AND, 5'd6, 5'd1, 5'd2, '0);  // Unrelated filler
    end
    for (int i = 0; i < 4; i++) begin
        issue_op(K_SUB, 5'd7, 5'd7, 5'd5, '0);
        idle_cycles(1);
    end
    wait_drain();
endtask

task automatic test_r0_and_unknown();
    cur_test = "test_r0_and_unknown";
    load_reg(5'd9, word_t'($urandom()));
    issue_op(K_ADD, 5'd0, 5'd9, 5'd9, '0);
    issue_op(K_LU12I, 5'd0, 5'd0, 5'd0, 20'hABCDE);
    issue_op(K_ADDI, 5'd0, 5'd9, 5'd0, 20'h00123);
    issue_op(K_OR, 5'd10, 5'd0, 5'd9, '0);
    issue_op(K_ADD, 5'd11, 5'd0, 5'd0, '0);
    issue_op(K_BAD, 5'd9, 5'd0, 5'd0, 20'h12345);
    issue_op(K_BAD, 5'd10, 5'd9, 5'd9, 20'h6789A);
    issue_op(K_XOR, 5'd12, 5'd9, 5'd10, '0);  // Both must be unchanged
    wait_drain();
endtask

task automatic test_mul_backpressure();
    cur_test = "test_mul_backpressure";
    ready_low_seen = 1'b0;
    load_reg(5'd1, word_t'($urandom()));
    load_reg(5'd2, word_t'($urandom()));
    issue_op(K_MUL, 5'd3, 5'd1, 5'd2, '0);
    for (int i = 0; i < `CORE_IB_DEPTH + 3; i++) begin
        issue_op(K_ADD, reg_addr_t'(4 + i), reg_addr_t'(3 + i), 5'd1, '0);
    end
    issue_op(K_MUL, 5'd20, 5'd3, 5'd4, '0);
    issue_op(K_MUL, 5'd21, 5'd20, 5'd20, '0);  // Back-to-back products
    issue_op(K_SUB, 5'd22, 5'd21, 5'd2, '0);
    wait_drain();
    if (!ready_low_seen) begin
        other_errs++;
        $display("fetch_ready_o never dropped while the multiplier was busy");
    end
endtask

task automatic test_commit_order_random();
    ins_kind_e   kind;
    reg_addr_t   rd;
    reg_addr_t   rj;
    reg_addr_t   rk;
    logic [19:0] imm;
    cur_test = "test_commit_order_random";
    for (int n = 0; n < 200; n++) begin
        kind = ins_kind_e'($urandom_range(0, 8));
        rd   = reg_addr_t'($urandom_range(0, 7));  // Small set, many hazards
        rj   = reg_addr_t'($urandom_range(0, 7));
        rk   = reg_addr_t'($urandom_range(0, 7));
        imm  = 20'($urandom());
        if ($urandom_range(0, 3) == 0) begin
            idle_cycles($urandom_range(1, 3));
        end
        issue_op(kind, rd, rj, rk, imm);
    end
    wait_drain();
endtask

`endif

/* tb_core_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "core_macros.svh"

module tb_core_top import core_isa_pkg::*, core_pipe_pkg::*;;

    localparam pc_t PC_START = 32'h1c00_0000;

    typedef enum int {
        K_ADD,
        K_SUB,
        K_AND,
        K_OR,
        K_XOR,
        K_MUL,
        K_ADDI,
        K_LU12I,
        K_BAD     // Matches no opcode
    } ins_kind_e;

    // One expected commit, in fetch order
    typedef struct packed {
        pc_t       pc;
        logic      known;   // Decodable, so wnum means something
        logic      wen;
        reg_addr_t wnum;
        word_t     wdata;
    } exp_commit_s;

    logic        clk;
    logic        rst_n_i;
    logic        fetch_valid_i;
    fetch_item_s fetch_item_i;
    logic        fetch_ready_o;
    logic        debug_wb_valid_o;
    pc_t         debug_wb_pc_o;
    logic        debug_wb_rf_wen_o;
    reg_addr_t   debug_wb_rf_wnum_o;
    word_t       debug_wb_rf_wdata_o;

    exp_commit_s exp_q [$];
    word_t       model_regs [`CORE_NREGS];
    pc_t         next_pc;
    string       cur_test;
    int          n_sent;
    int          cycle_cnt;
    int          mismatch_cnt;
    int          extra_commits;
    int          other_errs;
    logic        ready_low_seen;

    core_top DUT (
        .clk                 (clk),
        .rst_n_i             (rst_n_i),
        .fetch_valid_i       (fetch_valid_i),
        .fetch_item_i        (fetch_item_i),
        .fetch_ready_o       (fetch_ready_o),
        .debug_wb_valid_o    (debug_wb_valid_o),
        .debug_wb_pc_o       (debug_wb_pc_o),
        .debug_wb_rf_wen_o   (debug_wb_rf_wen_o),
        .debug_wb_rf_wnum_o  (debug_wb_rf_wnum_o),
        .debug_wb_rf_wdata_o (debug_wb_rf_wdata_o)
    );

    always #20 clk = ~clk;

    `include "tb_core_tasks.svh"

    // Limit grows by 40 cycles for every instruction sent
    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > 100 + 40 * n_sent) begin
            $display("Timeout after %0d cycles, %0d commits still outstanding",
                     cycle_cnt, exp_q.size());
            $display("TEST FAILED");
            $finish;
        end
    end

    // Commit monitor, sampled away from the rising edge
    always @(negedge clk) begin
        exp_commit_s head;
        if (rst_n_i && debug_wb_valid_o) begin
            if (exp_q.size() == 0) begin
                extra_commits++;
                $display("Commit at pc %h arrived with no instruction outstanding",
                         debug_wb_pc_o);
            end else begin
                head = exp_q.pop_front();
                check_pc(head.pc, debug_wb_pc_o);
                check_wen(head.wen, debug_wb_rf_wen_o);
                if (head.known) begin
                    check_wnum(head.wnum, debug_wb_rf_wnum_o);
                end
                if (head.wen) begin
                    check_wdata(head.wdata, debug_wb_rf_wdata_o);
                end
            end
        end
    end

    initial begin
        void'($urandom(18363));
        clk            = 1'b0;
        rst_n_i        = 1'b0;
        fetch_valid_i  = 1'b0;
        fetch_item_i   = '0;
        next_pc        = PC_START;
        cur_test       = "reset";
        n_sent         = 0;
        cycle_cnt      = 0;
        mismatch_cnt   = 0;
        extra_commits  = 0;
        other_errs     = 0;
        ready_low_seen = 1'b0;
        for (int i = 0; i < `CORE_NREGS; i++) begin
            model_regs[i] = '0;  // Register file resets to zero
        end

        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;
        if (fetch_ready_o !== 1'b1 || debug_wb_rf_wen_o !== 1'b0) begin
            other_errs++;
            $display("Ports wrong after reset: fetch_ready_o %b, debug_wb_rf_wen_o %b",
                     fetch_ready_o, debug_wb_rf_wen_o);
        end

        test_alu_basic();
        test_dependencies();
        test_r0_and_unknown();
        test_mul_backpressure();
        test_commit_order_random();

        idle_cycles(4);
        if (exp_q.size() != 0) begin
            other_errs++;
            $display("%0d expected commits never appeared", exp_q.size());
        end

        $display("Errors: %0d mismatches, %0d unexpected commits, %0d other failures",
                 mismatch_cnt, extra_commits, other_errs);
        if (mismatch_cnt + extra_commits + other_errs == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
+incdir+.
core_isa_pkg.sv
core_pipe_pkg.sv
instr_buffer.sv
decoder.sv
regfile.sv
dispatch.sv
alu_ex.sv
core_top.sv
tb_core_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ns --top-module tb_core_top -f project.f

out=$(./obj_dir/Vtb_core_top)
echo "$out"

if echo "$out" | grep -q "TEST PASSED"; then
    exit 0
fi
exit 1
